// File: verilog.f
hdl/spm_pkg.sv
hdl/spm_ram_if.sv
hdl/mp_ram.sv
hdl/apb_spm_slave.sv
hdl/fill_engine.sv
hdl/spm_top.sv
test/spm_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the scratchpad testbench with Verilator
# The exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module spm_tb \
  -Mdir obj_dir \
  -o spm_sim

./obj_dir/spm_sim

// File: test/spm_tb.sv
// ====================================================================
// Self-checking testbench for the scratchpad subsystem over APB
// Reference model assumes DEPTH 256 and WMODE 1 in the DUT
// APB inputs change on the falling edge, outputs sampled mid low phase
// Any mismatch or timeout ends the run through $fatal
// ====================================================================

module spm_tb import spm_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 256;
  // Upper bounds on the traffic below, used for the watchdog
  localparam int MAX_XFERS      = 1000;
  localparam int MAX_FILL_WORDS = 300;
  localparam int LIMIT_CYCLES   = MAX_XFERS * 4 + MAX_FILL_WORDS + 1000;

  logic               clk;
  logic               rst_n;
  logic [PADDR_W-1:0] paddr;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [DATA_W-1:0]  pwdata;
  logic [STRB_W-1:0]  pstrb;
  logic [DATA_W-1:0]  prdata;
  logic               pready;
  logic               pslverr;

  // Expected memory contents
  logic [31:0] model_mem [DEPTH];

  // Pending comparisons, filled by the stimulus
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       tag_q [$];

  logic [7:0]  hist [$];
  integer      seed;
  logic [31:0] r;
  logic [31:0] d;
  logic [31:0] pat;
  logic [7:0]  word;
  logic [7:0]  s;
  logic [8:0]  cnt;
  logic [3:0]  strb;
  int          idx;

  spm_top #(.DEPTH(DEPTH), .WMODE(1'b1)) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] model_read(input logic [7:0] w);
    return model_mem[w];
  endfunction

  // Byte merge by strobe
  function automatic void model_write(input logic [7:0] w, input logic [31:0] data,
                                      input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        model_mem[w][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endfunction

  // Range wraps past the last word
  function automatic void model_fill(input logic [7:0] st, input logic [8:0] n,
                                     input logic [31:0] p);
    logic [7:0] w;
    w = st;
    for (int k = 0; k < int'(n); k++) begin
      model_mem[w] = p;
      w = w + 8'd1;
    end
  endfunction

  task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic expect_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    tag_q.push_back(what);
  endtask

  // One APB transfer, setup then access until pready
  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                          input logic [3:0] be, input int exp_waits,
                          output logic [31:0] rdata, output logic err);
    int waits;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = be;
    @(negedge clk);
    penable = 1'b1;
    waits   = 0;
    // Outputs settle well before the rising edge
    #5;
    while (!pready) begin
      waits++;
      @(negedge clk);
      #5;
    end
    rdata = prdata;
    err   = pslverr;
    // Accepted RAM reads take one wait state, all other transfers none
    expect_value(waits, exp_waits, $sformatf("wait states at 0x%03h", addr));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic ram_write(input logic [7:0] w, input logic [31:0] data, input logic [3:0] be,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, {2'b00, w, 2'b00}, data, be, 0, rd, err);
    expect_value({31'b0, err}, {31'b0, exp_err}, $sformatf("pslverr on write word %0d", w));
    if (!exp_err) begin
      model_write(w, data, be);
    end
  endtask

  task automatic ram_read(input logic [7:0] w, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, {2'b00, w, 2'b00}, '0, 4'h0, exp_err ? 0 : 1, rd, err);
    expect_value({31'b0, err}, {31'b0, exp_err}, $sformatf("pslverr on read word %0d", w));
    if (!exp_err) begin
      expect_value(rd, model_read(w), $sformatf("read word %0d", w));
    end
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, 4'hF, 0, rd, err);
    expect_value({31'b0, err}, {31'b0, exp_err}, $sformatf("pslverr on write 0x%03h", addr));
  endtask

  task automatic reg_read(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, '0, 4'h0, 0, rd, err);
    expect_value({31'b0, err}, 32'h0, $sformatf("pslverr on read 0x%03h", addr));
    expect_value(rd, exp, $sformatf("register 0x%03h", addr));
  endtask

  task automatic start_fill(input logic [7:0] st, input logic [8:0] n, input logic [31:0] p);
    reg_write(FILL_START, {24'b0, st}, 1'b0);
    reg_write(FILL_COUNT, {23'b0, n}, 1'b0);
    reg_write(FILL_PATTERN, p, 1'b0);
    reg_write(FILL_CTRL, 32'h1, 1'b0);
  endtask

  // Poll the done bit of FILL_CTRL
  task automatic wait_fill_done();
    logic [31:0] rd;
    logic        err;
    do begin
      apb_xfer(1'b0, FILL_CTRL, '0, 4'h0, 0, rd, err);
    end while (!rd[1]);
  endtask

  // Compare process
  initial begin
    forever begin
      @(posedge clk);
      while (got_q.size() > 0) begin
        compare_values(got_q.pop_front(), exp_q.pop_front(), tag_q.pop_front());
      end
    end
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: the DUT did not finish the tests within %0d cycles", LIMIT_CYCLES);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    pstrb   = '0;
    seed    = 32'heb27_a1de;
    for (int k = 0; k < DEPTH; k++) begin
      model_mem[k] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Power-up contents and idle control
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      ram_read(r[7:0], 1'b0);
    end
    reg_read(FILL_CTRL, 32'h0);

    // Random byte writes, each followed by a read of a written word
    for (int i = 0; i < 200; i++) begin
      r = $random(seed);
      word = r[7:0];
      strb = r[11:8];
      d = $random(seed);
      ram_write(word, d, strb, 1'b0);
      hist.push_back(word);
      r = $random(seed);
      idx = int'(r[15:0]) % hist.size();
      ram_read(hist[idx], 1'b0);
    end

    // Fill that wraps past the last word
    r = $random(seed);
    s = 8'd240 + {4'b0, r[3:0]};
    cnt = 9'd20 + {4'b0, r[8:4]};
    pat = $random(seed);
    start_fill(s, cnt, pat);
    wait_fill_done();
    model_fill(s, cnt, pat);
    for (int k = 0; k < int'(cnt); k++) begin
      ram_read(s + k[7:0], 1'b0);
    end
    ram_read(s - 8'd1, 1'b0);
    ram_read(s + cnt[7:0], 1'b0);

    // Accesses while a long fill is running
    r = $random(seed);
    s = r[7:0];
    cnt = 9'd200;
    pat = $random(seed);
    start_fill(s, cnt, pat);
    d = $random(seed);
    // Offsets 150 and 100 lie inside the 200 word range, 220 lies outside
    ram_write(s + 8'd150, d, 4'hF, 1'b1);
    ram_read(s + 8'd100, 1'b1);
    ram_write(s + 8'd220, d, 4'h5, 1'b0);
    reg_write(FILL_PATTERN, ~pat, 1'b1);
    wait_fill_done();
    model_fill(s, cnt, pat);
    reg_read(FILL_PATTERN, pat);
    for (int k = 0; k < DEPTH; k++) begin
      ram_read(k[7:0], 1'b0);
    end

    // Unmapped space has no effect
    apb_xfer(1'b1, 12'h410, 32'hdead_beef, 4'hF, 0, d, strb[0]);
    expect_value({31'b0, strb[0]}, 32'h1, "pslverr on unmapped write");
    apb_xfer(1'b0, 12'h7FC, '0, 4'h0, 0, d, strb[0]);
    expect_value({31'b0, strb[0]}, 32'h1, "pslverr on unmapped read");
    reg_read(FILL_START, {24'b0, s});
    reg_read(FILL_COUNT, {23'b0, cnt});

    // Empty fill only sets done
    r = $random(seed);
    start_fill(r[7:0], 9'd0, ~pat);
    wait_fill_done();
    model_fill(r[7:0], 9'd0, ~pat);
    reg_read(FILL_CTRL, 32'h2);
    ram_read(r[7:0], 1'b0);
    ram_read(r[7:0] + 8'd1, 1'b0);

    while (got_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: hdl/spm_top.sv
// ====================================================================
// Scratchpad subsystem top with an APB slave interface
// DEPTH must be a power of two no larger than 256
// WMODE 0 is read-first, 1 is write-first inside the RAM
// ====================================================================

module spm_top import spm_pkg::*; #(
  parameter int DEPTH = 256,
  parameter bit WMODE = 1'b1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [PADDR_W-1:0] paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [DATA_W-1:0]  pwdata,
  input  logic [STRB_W-1:0]  pstrb,
  output logic [DATA_W-1:0]  prdata,
  output logic               pready,
  output logic               pslverr
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Fill control between the slave and the engine
  logic [ADDR_W-1:0] start_word;
  logic [ADDR_W:0]   count;
  logic [DATA_W-1:0] pattern;
  logic              go;
  logic              busy;
  logic              done;

  // Port 0 for APB, port 1 for the fill engine
  spm_ram_if #(.DEPTH(DEPTH)) ram_p0 ();
  spm_ram_if #(.DEPTH(DEPTH)) ram_p1 ();

  apb_spm_slave #(.DEPTH(DEPTH)) u_apb (
    .clk        (clk),
    .rst_n      (rst_n),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .ram        (ram_p0.master),
    .busy       (busy),
    .done       (done),
    .start_word (start_word),
    .count      (count),
    .pattern    (pattern),
    .go         (go)
  );

  fill_engine #(.DEPTH(DEPTH)) u_fill (
    .clk        (clk),
    .rst_n      (rst_n),
    .go         (go),
    .start_word (start_word),
    .count      (count),
    .pattern    (pattern),
    .busy       (busy),
    .done       (done),
    .ram        (ram_p1.master)
  );

  mp_ram #(.DEPTH(DEPTH), .WMODE(WMODE)) u_ram (
    .clk (clk),
    .p0  (ram_p0.slave),
    .p1  (ram_p1.slave)
  );

endmodule

// File: hdl/fill_engine.sv
// ====================================================================
// Block fill sequencer on RAM port 1
// Writes one full word of the pattern per clock from start_word on,
// wrapping modulo DEPTH, and never stalls
// A count of zero only sets done
// ====================================================================

module fill_engine import spm_pkg::*; #(
  parameter int   DEPTH  = 256,
  localparam int  ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              go,
  input  logic [ADDR_W-1:0] start_word,
  input  logic [ADDR_W:0]   count,
  input  logic [DATA_W-1:0] pattern,
  output logic              busy,
  output logic              done,
  spm_ram_if.master         ram
);

  fill_state_e       state;
  // Word pointer, wraps by its width
  logic [ADDR_W-1:0] ptr;
  // Words still to write, including the current one
  logic [ADDR_W:0]   remain;
  logic [DATA_W-1:0] pat;
  logic              start;

  // Go is only taken when idle
  assign start = go && (state == FILL_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= FILL_IDLE;
      ptr    <= '0;
      remain <= '0;
      done   <= 1'b0;
    end else begin
      case (state)
        FILL_IDLE: begin
          if (start) begin
            ptr    <= start_word;
            remain <= count;
            // Empty range finishes right away
            done   <= (count == '0);
            if (count != '0) begin
              state <= FILL_RUN;
            end
          end
        end
        FILL_RUN: begin
          ptr    <= ptr + 1'b1;
          remain <= remain - 1'b1;
          // Last word goes out this cycle
          if (remain == (ADDR_W+1)'(1)) begin
            state <= FILL_IDLE;
            done  <= 1'b1;
          end
        end
        default: begin
          state <= FILL_IDLE;
        end
      endcase
    end
  end

  // Pattern copy for the length of one fill
  always_ff @(posedge clk) begin
    if (start) begin
      pat <= pattern;
    end
  end

  assign busy = (state == FILL_RUN);

  // Full word writes while running
  assign ram.en    = {STRB_W{busy}};
  assign ram.rw_   = 1'b0;
  assign ram.addr  = ptr;
  assign ram.wdata = pat;

  a_go_idle: assert property (
    @(posedge clk) disable iff (!rst_n) go |-> !busy
  ) else $error("fill go while busy");

endmodule

// File: hdl/apb_spm_slave.sv
// ====================================================================
// APB slave for the RAM window and the four fill engine registers
// RAM reads take one wait state, everything else completes at once
// Fill registers take full words, pstrb only applies to RAM writes
// RAM words beyond DEPTH alias into the array when DEPTH < 256
// ====================================================================

module apb_spm_slave import spm_pkg::*; #(
  parameter int   DEPTH  = 256,
  localparam int  ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [PADDR_W-1:0] paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [DATA_W-1:0]  pwdata,
  input  logic [STRB_W-1:0]  pstrb,
  output logic [DATA_W-1:0]  prdata,
  output logic               pready,
  output logic               pslverr,
  spm_ram_if.master          ram,
  input  logic               busy,
  input  logic               done,
  output logic [ADDR_W-1:0]  start_word,
  output logic [ADDR_W:0]    count,
  output logic [DATA_W-1:0]  pattern,
  output logic               go
);

  apb_state_e        state;
  reg_sel_e          sel;
  logic              acc;
  logic              is_ram;
  logic              is_reg;
  logic              unmapped;
  logic [ADDR_W-1:0] ram_word;
  logic [ADDR_W-1:0] fill_off;
  logic              range_hit;
  logic              err;
  logic              ram_rd;
  logic              reg_wr;
  logic [DATA_W-1:0] reg_rdata;

  // First access cycle of a transfer
  assign acc = (state == APB_ACCESS) && psel && penable;

  // Address decode
  assign is_ram   = paddr < PADDR_W'(RAM_SPAN);
  assign unmapped = paddr > PADDR_W'(FILL_CTRL);
  assign is_reg   = !is_ram && !unmapped;
  assign sel      = reg_sel_e'({paddr[PADDR_W-1:2], 2'b00});
  assign ram_word = paddr[ADDR_W+1:2];

  // Word offset into the running fill, wraps modulo DEPTH
  assign fill_off  = ram_word - start_word;
  assign range_hit = busy && ({1'b0, fill_off} < count);

  // Rejected accesses have no side effect
  assign err = unmapped
             || (is_ram && range_hit)
             || (is_reg && pwrite && busy && (sel != FILL_CTRL));

  assign ram_rd = acc && is_ram && !pwrite && !err;
  assign reg_wr = acc && is_reg && pwrite && !err;

  // RAM port 0 is driven only in the first access cycle
  assign ram.en    = (acc && is_ram && !err) ? (pwrite ? pstrb : '1) : '0;
  assign ram.rw_   = !pwrite;
  assign ram.addr  = ram_word;
  assign ram.wdata = pwdata;

  // Completion, a good RAM read waits one cycle for the read register
  assign pready  = (acc && !ram_rd) || (state == APB_READ_WAIT);
  assign pslverr = acc && err;

  always_comb begin
    case (sel)
      FILL_START:   reg_rdata = DATA_W'(start_word);
      FILL_COUNT:   reg_rdata = DATA_W'(count);
      FILL_PATTERN: reg_rdata = pattern;
      FILL_CTRL:    reg_rdata = {{(DATA_W-2){1'b0}}, done, busy};
      default:      reg_rdata = '0;
    endcase
  end

  assign prdata = (state == APB_READ_WAIT) ? ram.rdata
                : (is_reg ? reg_rdata : '0);

  // Transfer phase tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= APB_IDLE;
    end else begin
      case (state)
        APB_IDLE: begin
          if (psel && !penable) begin
            state <= APB_ACCESS;
          end
        end
        APB_ACCESS: begin
          state <= ram_rd ? APB_READ_WAIT : APB_IDLE;
        end
        default: begin
          state <= APB_IDLE;
        end
      endcase
    end
  end

  // Fill registers and the go pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_word <= '0;
      count      <= '0;
      pattern    <= '0;
      go         <= 1'b0;
    end else begin
      go <= 1'b0;
      if (reg_wr) begin
        case (sel)
          FILL_START:   start_word <= pwdata[ADDR_W-1:0];
          FILL_COUNT:   count <= pwdata[ADDR_W:0];
          FILL_PATTERN: pattern <= pwdata;
          // Start request is dropped while a fill is running
          FILL_CTRL:    go <= pwdata[0] && !busy && !go;
          default: ;
        endcase
      end
    end
  end

  a_penable_psel: assert property (
    @(posedge clk) disable iff (!rst_n) penable |-> psel
  ) else $error("penable high without psel");

endmodule

// File: hdl/mp_ram.sv
// ====================================================================
// Two-port flip-flop RAM with byte enables and registered read data
// Contents start at zero and are not touched by reset
// Port 1 wins when both ports write the same byte in one cycle
// WMODE 1 forwards same-cycle writes of the other port into a read
// ====================================================================

module mp_ram import spm_pkg::*; #(
  parameter int DEPTH = 256,
  parameter bit WMODE = 1'b1
) (
  input logic     clk,
  spm_ram_if.slave p0,
  spm_ram_if.slave p1
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int BYTE_W = DATA_W / STRB_W;

  // Storage array
  logic [DATA_W-1:0] mem [DEPTH];

  // Both ports gathered so the logic below can loop over them
  logic [STRB_W-1:0] en_a    [2];
  logic              rw_a    [2];
  logic [ADDR_W-1:0] addr_a  [2];
  logic [DATA_W-1:0] wdata_a [2];
  logic [DATA_W-1:0] rd_next [2];
  logic [DATA_W-1:0] rdata_q [2];
  logic [1:0]        ren;
  logic [1:0]        wen;

  always_comb begin
    en_a[0]    = p0.en;
    rw_a[0]    = p0.rw_;
    addr_a[0]  = p0.addr;
    wdata_a[0] = p0.wdata;
    en_a[1]    = p1.en;
    rw_a[1]    = p1.rw_;
    addr_a[1]  = p1.addr;
    wdata_a[1] = p1.wdata;
  end

  // Read and write strobes per port
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      ren[i] = rw_a[i] & (|en_a[i]);
      wen[i] = ~rw_a[i] & (|en_a[i]);
    end
  end

  // Next read word, with bytes of the other port's write forwarded
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rd_next[i] = mem[addr_a[i]];
      if (WMODE && wen[1-i] && (addr_a[1-i] == addr_a[i])) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (en_a[1-i][b]) begin
            rd_next[i][b*BYTE_W +: BYTE_W] = wdata_a[1-i][b*BYTE_W +: BYTE_W];
          end
        end
      end
    end
  end

  // Read register holds its word until the next read
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (ren[i]) begin
        rdata_q[i] <= rd_next[i];
      end
    end
  end

  assign p0.rdata = rdata_q[0];
  assign p1.rdata = rdata_q[1];

  // Byte writes, port 1 last so it overrides port 0
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (wen[i]) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (en_a[i][b]) begin
            mem[addr_a[i]][b*BYTE_W +: BYTE_W] <= wdata_a[i][b*BYTE_W +: BYTE_W];
          end
        end
      end
    end
  end

  // Power-up contents
  initial begin
    for (int k = 0; k < DEPTH; k++) begin
      mem[k] = '0;
    end
  end

  for (genvar g = 0; g < 2; g++) begin : g_port_chk
    // Requesters must stay inside the array
    a_addr_range: assert property (
      @(posedge clk) (|en_a[g]) |-> (int'(addr_a[g]) < DEPTH)
    ) else $error("mp_ram port %0d address out of range", g);

    // Partial reads are not defined for this RAM
    a_full_read: assert property (
      @(posedge clk) ren[g] |-> (&en_a[g])
    ) else $error("mp_ram port %0d read without all byte enables", g);
  end

endmodule

// File: hdl/spm_ram_if.sv
// ====================================================================
// One shared read/write port of the scratchpad RAM
// rw_ high selects a read, and a read must enable every byte lane
// A port does nothing in a cycle where all en bits are low
// ====================================================================

interface spm_ram_if import spm_pkg::*; #(
  parameter int DEPTH = 256
) ();

  // Word address width, kept at least one bit wide
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  // Per byte access enables
  logic [STRB_W-1:0] en;
  // Read high, write low
  logic              rw_;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  // Registered read data from the RAM
  logic [DATA_W-1:0] rdata;

  // Requester side
  modport master (
    output en, rw_, addr, wdata,
    input  rdata
  );

  // RAM side
  modport slave (
    input  en, rw_, addr, wdata,
    output rdata
  );

endinterface

// File: hdl/spm_pkg.sv
// ====================================================================
// Shared widths, APB address map and FSM state types of the scratchpad
// The RAM window is fixed at 1 KiB no matter how deep the RAM is built
// Enum literals carry a prefix since every FSM shares this one scope
// ====================================================================

package spm_pkg;

  // One data word on APB and in the RAM
  localparam int DATA_W = 32;

  // Byte lanes per word
  localparam int STRB_W = 4;

  // APB byte address width
  localparam int PADDR_W = 12;

  // RAM window spans 0x000 to 0x3FF
  localparam int RAM_SPAN = 'h400;

  // Fill engine registers right above the RAM window
  typedef enum logic [PADDR_W-1:0] {
    FILL_START   = 12'h400,
    FILL_COUNT   = 12'h404,
    FILL_PATTERN = 12'h408,
    FILL_CTRL    = 12'h40C
  } reg_sel_e;

  // APB slave phases
  typedef enum logic [1:0] {
    APB_IDLE,
    APB_ACCESS,
    APB_READ_WAIT
  } apb_state_e;

  // Fill sequencer states
  typedef enum logic {
    FILL_IDLE,
    FILL_RUN
  } fill_state_e;

endpackage
